//--- source/cutter_cfg.svh
/*
 Build-time configuration of the packet cutter.
 CUT_HASH_BYTES must be half of CUT_DATA_BYTES, because the hash is
 the XOR of the two halves of a word.
 Register addresses are byte addresses and must fit in CUT_APB_ADDR_WIDTH.
*/
`ifndef CUTTER_CFG_SVH
`define CUTTER_CFG_SVH

// Stream word size
`define CUT_DATA_BYTES 8
`define CUT_HASH_BYTES 4

// Up to 255 kept words per packet
`define CUT_COUNT_WIDTH 8

// Input buffer of 8 words
`define CUT_FIFO_DEPTH_BITS 3

`define CUT_APB_ADDR_WIDTH 4
`define CUT_ADDR_CTRL 0
`define CUT_ADDR_WORDS 4

`endif

//--- source/cutter_pkg.sv
/*
 Types shared by the packet cutter blocks.
 All widths come from the cfg header. APB data is fixed at 32 bits.
*/
`include "cutter_cfg.svh"

package cutter_pkg;
	typedef logic [`CUT_DATA_BYTES*8-1:0]     axis_data_t;
	typedef logic [`CUT_DATA_BYTES-1:0]       axis_keep_t;
	typedef logic [`CUT_HASH_BYTES*8-1:0]     hash_t;
	typedef logic [`CUT_COUNT_WIDTH-1:0]      word_count_t;
	typedef logic [`CUT_APB_ADDR_WIDTH-1:0]   apb_addr_t;
	typedef logic [31:0]                      apb_data_t;

	typedef struct packed {
		axis_data_t data;
		axis_keep_t keep;   // Contiguous from byte 0
		logic       last;
	} axis_word_t;

	typedef struct packed {
		logic        en;
		word_count_t words;   // Kept words per packet
	} cut_cfg_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	typedef enum logic [1:0] {FORWARD, DRAIN, SEND_HASH} cut_state_t;
endpackage

//--- source/cutter_apb_regs.sv
/*
 APB configuration registers of the packet cutter.
 Zero wait states, pready is tied high.
 Unused addresses answer with pslverr and writes to them are dropped.
 A word count of zero with cutting enabled is not supported.
*/
`timescale 1ns/10ps
`include "cutter_cfg.svh"

module cutter_apb_regs import cutter_pkg::*; (
	input  logic      axi_aclk,
	input  logic      axi_resetn,
	input  apb_req_t  apb_req,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	output cut_cfg_t  cfg
);
	logic     access;   // Access phase of a transfer
	logic     hit_ctrl;
	logic     hit_words;
	cut_cfg_t cfg_q;

	assign access    = apb_req.psel & apb_req.penable;
	assign hit_ctrl  = apb_req.paddr == apb_addr_t'(`CUT_ADDR_CTRL);
	assign hit_words = apb_req.paddr == apb_addr_t'(`CUT_ADDR_WORDS);

	assign pready  = 1'b1;
	assign pslverr = access & ~(hit_ctrl | hit_words);
	assign cfg     = cfg_q;

	// Read mux, zero on a miss
	always_comb begin
		prdata = '0;
		if (hit_ctrl)
			prdata = apb_data_t'(cfg_q.en);
		else if (hit_words)
			prdata = apb_data_t'(cfg_q.words);
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			cfg_q <= '0;   // Cutting off
		end else if (access && apb_req.pwrite) begin
			if (hit_ctrl)
				cfg_q.en <= apb_req.pwdata[0];
			if (hit_words)
				cfg_q.words <= apb_req.pwdata[`CUT_COUNT_WIDTH-1:0];
		end
	end

	// Setup phase must come first
	penable_needs_psel: assert property (
		@(posedge axi_aclk) disable iff (!axi_resetn)
		$rose(apb_req.penable) |-> apb_req.psel
	) else $error("APB penable rose without psel");

endmodule

//--- source/word_fifo.sv
/*
 Fall-through FIFO for stream words.
 The head word is valid on rd_word whenever empty is low.
 wr_ready drops with fewer than two free entries, and a word offered
 while it is low is not taken.
*/
`timescale 1ns/10ps
`include "cutter_cfg.svh"

module word_fifo import cutter_pkg::*; #(
	parameter int DEPTH_BITS = `CUT_FIFO_DEPTH_BITS
) (
	input  logic       axi_aclk,
	input  logic       axi_resetn,
	input  axis_word_t wr_word,
	input  logic       wr_valid,
	output logic       wr_ready,
	input  logic       rd,
	output axis_word_t rd_word,
	output logic       empty
);
	localparam int DEPTH = 1 << DEPTH_BITS;

	axis_word_t            mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   fill;   // Entries in use
	logic                  push;
	logic                  pop;

	assign wr_ready = fill <= (DEPTH_BITS+1)'(DEPTH - 2);
	assign empty    = fill == '0;
	assign push     = wr_valid & wr_ready;
	assign pop      = rd & ~empty;
	assign rd_word  = mem[rd_ptr];

	always_ff @(posedge axi_aclk) begin
		if (push)
			mem[wr_ptr] <= wr_word;
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;   // Both or neither
			endcase
		end
	end

	no_pop_empty: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
		rd |-> !empty) else $error("FIFO popped while empty");

	// A write must never land on an unread entry
	no_push_full: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
		push && !empty |-> wr_ptr != rd_ptr) else $error("FIFO written while full");

endmodule

//--- source/cut_hash_engine.sv
/*
 Cut and hash engine.
 Forwards the first cfg.words words of a packet, then swallows the tail
 and closes the packet with one hash word in the low CUT_HASH_BYTES bytes.
 The configuration is sampled when the first word of a packet reaches
 the FIFO head; later changes apply from the next packet.
 Packets no longer than the word count pass whole without a hash.
*/
`timescale 1ns/10ps
`include "cutter_cfg.svh"

module cut_hash_engine import cutter_pkg::*; (
	input  logic       axi_aclk,
	input  logic       axi_resetn,
	input  cut_cfg_t   cfg,
	input  axis_word_t fifo_word,
	input  logic       fifo_empty,
	output logic       fifo_rd,
	output axis_word_t m_axis,
	output logic       m_axis_tvalid,
	input  logic       m_axis_tready
);
	localparam int HASH_BITS = `CUT_HASH_BYTES * 8;

	cut_state_t  state;
	cut_cfg_t    cfg_q;     // Config of the packet in flight
	cut_cfg_t    pkt_cfg;
	logic        sop_q;     // Waiting for the first word of a packet
	word_count_t fwd_cnt;   // Words forwarded so far
	axis_data_t  acc;
	axis_data_t  masked;
	hash_t       hash;
	logic        cut_here;

	// Live config until the first word has been seen
	assign pkt_cfg = sop_q ? cfg : cfg_q;

	// Head word is the last one to keep, and the packet goes on
	assign cut_here = pkt_cfg.en && !fifo_word.last &&
		(fwd_cnt == pkt_cfg.words - 1'b1);

	// Unkept bytes of a tail word do not count
	always_comb begin
		for (int i = 0; i < `CUT_DATA_BYTES; i++)
			masked[8*i +: 8] = fifo_word.keep[i] ? fifo_word.data[8*i +: 8] : 8'h00;
	end

	assign hash = acc[2*HASH_BITS-1 -: HASH_BITS] ^ acc[HASH_BITS-1:0];

	always_comb begin
		m_axis        = fifo_word;
		m_axis_tvalid = 1'b0;
		fifo_rd       = 1'b0;
		case (state)
			FORWARD: begin
				m_axis_tvalid = !fifo_empty;
				fifo_rd       = !fifo_empty && m_axis_tready;
			end
			DRAIN: begin
				fifo_rd = !fifo_empty;   // Tail words never leave
			end
			SEND_HASH: begin
				m_axis.data   = axis_data_t'(hash);
				m_axis.keep   = axis_keep_t'({`CUT_HASH_BYTES{1'b1}});
				m_axis.last   = 1'b1;
				m_axis_tvalid = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge axi_aclk) begin
		if (!axi_resetn) begin
			state   <= FORWARD;
			cfg_q   <= '0;
			sop_q   <= 1'b1;
			fwd_cnt <= '0;
		end else begin
			if (sop_q && !fifo_empty) begin
				cfg_q <= cfg;
				sop_q <= 1'b0;
			end
			case (state)
				FORWARD: begin
					if (fifo_rd) begin
						fwd_cnt <= fwd_cnt + 1'b1;
						if (fifo_word.last) begin
							sop_q   <= 1'b1;   // Short packet, no hash
							fwd_cnt <= '0;
						end else if (cut_here) begin
							state <= DRAIN;
						end
					end
				end
				DRAIN: begin
					if (fifo_rd && fifo_word.last)
						state <= SEND_HASH;
				end
				SEND_HASH: begin
					if (m_axis_tready) begin
						state   <= FORWARD;
						sop_q   <= 1'b1;
						fwd_cnt <= '0;
					end
				end
				default: state <= FORWARD;
			endcase
		end
	end

	// Tail accumulator, cleared while forwarding
	always_ff @(posedge axi_aclk) begin
		if (state == FORWARD)
			acc <= '0;
		else if (state == DRAIN && fifo_rd)
			acc <= acc ^ masked;
	end

	out_stable: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis))
		else $error("Output word changed while stalled");

	cut_count_nonzero: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
		!sop_q && cfg_q.en |-> cfg_q.words != '0)
		else $error("Cutting enabled with a word count of zero");

endmodule

//--- source/packet_cutter_top.sv
/*
 Packet cutter top level.
 Input words pass through a small buffer, then the cut and hash engine.
 Configuration is written over APB; it is off after reset.
 Output latency varies, m_axis.last marks each packet end.
*/
`timescale 1ns/10ps

module packet_cutter_top import cutter_pkg::*; (
	input  logic       axi_aclk,
	input  logic       axi_resetn,
	input  apb_req_t   apb_req,
	output apb_data_t  prdata,
	output logic       pready,
	output logic       pslverr,
	input  axis_word_t s_axis,
	input  logic       s_axis_tvalid,
	output logic       s_axis_tready,
	output axis_word_t m_axis,
	output logic       m_axis_tvalid,
	input  logic       m_axis_tready
);
	cut_cfg_t   cfg;
	axis_word_t fifo_word;
	logic       fifo_empty;
	logic       fifo_rd;

	cutter_apb_regs u_regs (
		.axi_aclk   (axi_aclk),
		.axi_resetn (axi_resetn),
		.apb_req    (apb_req),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.cfg        (cfg)
	);

	word_fifo u_fifo (
		.axi_aclk   (axi_aclk),
		.axi_resetn (axi_resetn),
		.wr_word    (s_axis),
		.wr_valid   (s_axis_tvalid),
		.wr_ready   (s_axis_tready),
		.rd         (fifo_rd),
		.rd_word    (fifo_word),
		.empty      (fifo_empty)
	);

	cut_hash_engine u_engine (
		.axi_aclk      (axi_aclk),
		.axi_resetn    (axi_resetn),
		.cfg           (cfg),
		.fifo_word     (fifo_word),
		.fifo_empty    (fifo_empty),
		.fifo_rd       (fifo_rd),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

endmodule

//--- verification/tb_packet_cutter.sv
/*
 Testbench for the packet cutter.
 Stream tests come from a table, packet data and output stalls from an LCG.
 Expected output is rebuilt by a queue model of the cut and hash rules.
 Assumes the cfg header defaults: 64-bit words, 32-bit hash, 8-bit count.
*/
`timescale 1ns/10ps
`include "cutter_cfg.svh"

module tb_packet_cutter import cutter_pkg::*; ();
	localparam int TIMEOUT = 200;   // Cycles per wait loop
	localparam int N_TESTS = 10;
	localparam int HASH_BITS = `CUT_HASH_BYTES * 8;
	localparam apb_addr_t ADDR_CTRL = apb_addr_t'(`CUT_ADDR_CTRL);
	localparam apb_addr_t ADDR_WORDS = apb_addr_t'(`CUT_ADDR_WORDS);
	localparam apb_addr_t ADDR_BAD = apb_addr_t'(8);

	typedef struct packed {
		logic        en;
		word_count_t words;
		int          len;          // Packet length in words
		int          last_bytes;   // Bytes kept in the last word
		logic        bp;           // Random output stalls
	} test_row_t;

	logic       axi_aclk;
	logic       axi_resetn;
	apb_req_t   apb_req;
	apb_data_t  prdata;
	logic       pready;
	logic       pslverr;
	axis_word_t s_axis;
	logic       s_axis_tvalid;
	logic       s_axis_tready;
	axis_word_t m_axis;
	logic       m_axis_tvalid;
	logic       m_axis_tready;

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	int          tests_done;
	axis_word_t  sent_q[$];
	axis_word_t  exp_q[$];

	test_row_t rows [N_TESTS] = '{
		'{1'b0, 8'd3, 1, 8, 1'b0},
		'{1'b0, 8'd3, 5, 3, 1'b0},
		'{1'b0, 8'd2, 9, 1, 1'b1},
		'{1'b1, 8'd3, 7, 5, 1'b0},
		'{1'b1, 8'd1, 4, 8, 1'b0},
		'{1'b1, 8'd6, 14, 2, 1'b0},
		'{1'b1, 8'd4, 4, 6, 1'b0},   // Equal to the count, no hash
		'{1'b1, 8'd5, 2, 7, 1'b0},
		'{1'b1, 8'd2, 10, 4, 1'b1},
		'{1'b1, 8'd6, 3, 1, 1'b1}
	};

	packet_cutter_top DUT (
		.axi_aclk      (axi_aclk),
		.axi_resetn    (axi_resetn),
		.apb_req       (apb_req),
		.prdata        (prdata),
		.pready        (pready),
		.pslverr       (pslverr),
		.s_axis        (s_axis),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis        (m_axis),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready)
	);

	initial begin
		axi_aclk = 1'b0;
		forever #10 axi_aclk = ~axi_aclk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_word(input axis_word_t got, input axis_word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s is data %h keep %h last %b, expected data %h keep %h last %b",
				$time, what, got.data, got.keep, got.last, exp.data, exp.keep, exp.last);
		end
	endtask

	task automatic check_reg(input apb_data_t got, input apb_data_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Called at 2 ns after a rising edge, returns at the same point
	task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waited;
		waited = 0;
		apb_req.psel    = 1'b1;   // Setup phase
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge axi_aclk);
		#2;
		apb_req.penable = 1'b1;
		@(negedge axi_aclk);
		while (!pready && waited < TIMEOUT) begin
			waited++;
			@(negedge axi_aclk);
		end
		if (!pready) begin
			errors++;
			$display("APB access to address %h never got pready", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge axi_aclk);
		#2;
		apb_req = '0;
	endtask

	task automatic build_expected(input test_row_t row);
		axis_data_t acc;
		axis_word_t hw;
		logic       cut;
		exp_q = {};
		acc   = '0;
		cut   = row.en && sent_q.size() > int'(row.words);
		for (int i = 0; i < sent_q.size(); i++) begin
			if (!cut || i < int'(row.words)) begin
				exp_q.push_back(sent_q[i]);
			end else begin
				for (int b = 0; b < `CUT_DATA_BYTES; b++)
					if (sent_q[i].keep[b])
						acc[8*b +: 8] = acc[8*b +: 8] ^ sent_q[i].data[8*b +: 8];
			end
		end
		if (cut) begin
			hw.data = axis_data_t'(hash_t'(acc >> HASH_BITS) ^ hash_t'(acc));
			hw.keep = axis_keep_t'(8'h0F);
			hw.last = 1'b1;
			exp_q.push_back(hw);
		end
	endtask

	task automatic send_packet();
		int waited;
		for (int i = 0; i < sent_q.size(); i++) begin
			s_axis        = sent_q[i];
			s_axis_tvalid = 1'b1;
			waited        = 0;
			@(negedge axi_aclk);
			while (!s_axis_tready && waited < TIMEOUT) begin
				waited++;
				@(negedge axi_aclk);
			end
			if (!s_axis_tready) begin
				errors++;
				$display("Input stream stuck, s_axis_tready stayed low at word %0d", i);
				break;
			end
			@(posedge axi_aclk);   // Word accepted here
			#2;
		end
		s_axis_tvalid = 1'b0;
	endtask

	task automatic receive_packet(input logic bp);
		int          got;
		int          idle;
		logic [31:0] rnd;
		got  = 0;
		idle = 0;
		while (got < exp_q.size() && idle < TIMEOUT) begin
			rnd           = next_random();
			m_axis_tready = bp ? rnd[16] : 1'b1;
			@(negedge axi_aclk);
			if (m_axis_tvalid && m_axis_tready) begin
				check_word(m_axis, exp_q[got], $sformatf("output word %0d", got));
				got++;
				idle = 0;
			end else begin
				idle++;
			end
			@(posedge axi_aclk);
			#2;
		end
		m_axis_tready = 1'b1;   // Lets any extra word show up
		if (got < exp_q.size()) begin
			errors++;
			$display("Output stream stalled, got %0d of %0d words", got, exp_q.size());
		end
	endtask

	task automatic run_row(input test_row_t row);
		axis_word_t w;
		apb_data_t  rd;
		logic       err;
		apb_access(1'b1, ADDR_CTRL, apb_data_t'(row.en), rd, err);
		apb_access(1'b1, ADDR_WORDS, apb_data_t'(row.words), rd, err);
		sent_q = {};
		for (int i = 0; i < row.len; i++) begin
			w.data = {next_random(), next_random()};
			w.last = i == row.len - 1;
			w.keep = w.last ? axis_keep_t'(8'hFF >> (8 - row.last_bytes)) : axis_keep_t'(8'hFF);
			sent_q.push_back(w);
		end
		build_expected(row);
		fork
			send_packet();
			receive_packet(row.bp);
		join
		repeat (3) begin
			@(negedge axi_aclk);
			check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid after packet end");
		end
		@(posedge axi_aclk);
		#2;
	endtask

	task automatic report_test(input int num, input string name, input int start_errors);
		tests_done++;
		$display("Test %0d %s: %0d errors", num, name, errors - start_errors);
	endtask

	initial begin
		apb_data_t rd;
		logic      err;
		int        start;
		lcg_state     = 32'hb214;
		errors        = 0;
		checks        = 0;
		tests_done    = 0;
		apb_req       = '0;
		s_axis        = '0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		axi_resetn    = 1'b0;
		repeat (4) @(posedge axi_aclk);
		#2 axi_resetn = 1'b1;

		start = errors;
		@(negedge axi_aclk);
		check_flag(m_axis_tvalid, 1'b0, "m_axis_tvalid after reset");
		check_flag(s_axis_tready, 1'b1, "s_axis_tready after reset");
		@(posedge axi_aclk);
		#2;
		apb_access(1'b0, ADDR_CTRL, '0, rd, err);
		check_reg(rd, 32'h0, "control register after reset");
		check_flag(err, 1'b0, "pslverr on control read");
		apb_access(1'b0, ADDR_WORDS, '0, rd, err);
		check_reg(rd, 32'h0, "word count register after reset");
		report_test(0, "reset state", start);

		start = errors;
		apb_access(1'b1, ADDR_CTRL, 32'h1, rd, err);
		apb_access(1'b1, ADDR_WORDS, 32'h5A, rd, err);
		apb_access(1'b0, ADDR_CTRL, '0, rd, err);
		check_reg(rd, 32'h1, "control register");
		apb_access(1'b0, ADDR_WORDS, '0, rd, err);
		check_reg(rd, 32'h5A, "word count register");
		apb_access(1'b1, ADDR_BAD, 32'h0, rd, err);   // Would clear both on a false hit
		check_flag(err, 1'b1, "pslverr on unused write");
		apb_access(1'b0, ADDR_BAD, '0, rd, err);
		check_flag(err, 1'b1, "pslverr on unused read");
		apb_access(1'b0, ADDR_CTRL, '0, rd, err);
		check_reg(rd, 32'h1, "control register after unused write");
		apb_access(1'b0, ADDR_WORDS, '0, rd, err);
		check_reg(rd, 32'h5A, "word count register after unused write");
		report_test(1, "APB registers", start);

		for (int t = 0; t < N_TESTS; t++) begin
			start = errors;
			run_row(rows[t]);
			report_test(t + 2, $sformatf("stream en %0b count %0d length %0d stalls %0b",
				rows[t].en, rows[t].words, rows[t].len, rows[t].bp), start);
		end

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/cutter_pkg.sv
source/cutter_apb_regs.sv
source/word_fifo.sv
source/cut_hash_engine.sv
source/packet_cutter_top.sv
verification/tb_packet_cutter.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the packet cutter testbench with Verilator and runs it.
# The exit status is zero only when the testbench reports a clean run.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_packet_cutter -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vtb_packet_cutter)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -Fqx "Finished with no errors"; then
	exit 0
fi
echo "Testbench reported errors"
exit 1
